/* MonopixPkg.sv */
package MonopixPkg;

    // Periphery dimensions
    localparam int NumFlavors  = 4;    // PmosNosf, Pmos, Comp, Hv
    localparam int NumCols     = 8;    // Columns per flavor
    localparam int BcidWidth   = 6;
    localparam int FifoDepth   = 4;    // Events per flavor buffer
    localparam int FlavorWidth = $clog2(NumFlavors);

    // One bit per column of one flavor
    typedef logic [NumCols-1:0] colVecT;

    // All columns, indexed by flavor first
    typedef colVecT [NumFlavors-1:0] hitVecT;

    // Configuration word, first member sits at the MSB end of the chain
    typedef struct packed {
        logic [NumFlavors-1:0] EnFlavor;    // Event generation per flavor
        logic [NumFlavors-1:0] EnHitOr;     // Hit-OR output per flavor
        colVecT                ColPulseSel; // Injection columns, shared by all flavors
        hitVecT                MaskCol;     // 1 enables the column
    } confT;

    localparam int ConfWidth = $bits(confT);

    // Everything enabled, no injection
    localparam confT ConfDefault = '{
        EnFlavor:    '1,
        EnHitOr:     '1,
        ColPulseSel: '0,
        MaskCol:     '1
    };

    // One captured hit event of a single flavor
    typedef struct packed {
        colVecT                 Cols;
        logic [BcidWidth-1:0]   Bcid;  // Gray coded
    } eventT;

    // Word handed out over the req/ack port
    typedef struct packed {
        logic [FlavorWidth-1:0] Flavor;
        colVecT                 Cols;
        logic [BcidWidth-1:0]   Bcid;
    } outWordT;

endpackage

/* ConfigReg.sv */
`timescale 1ns/1ps

module ConfigReg import MonopixPkg::*; (
    input  logic ClkBx,
    input  logic reset_ff,
    input  logic ConfShiftEn,
    input  logic ConfSi,
    input  logic ConfLoad,
    output logic ConfSo,
    output confT Conf
);

    logic [ConfWidth-1:0] chain;

    // Serial chain, LSB in and MSB out
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            chain <= ConfDefault;
        end else if (ConfShiftEn) begin
            chain <= {chain[ConfWidth-2:0], ConfSi};
        end
    end

    assign ConfSo = chain[ConfWidth-1];

    // Active copy seen by the periphery
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            Conf <= ConfDefault;
        end else if (ConfLoad) begin
            Conf <= confT'(chain);
        end
    end

    // A load during a shift would latch a half-shifted word
    assert property (@(posedge ClkBx) disable iff (reset_ff)
        !(ConfLoad && ConfShiftEn))
        else $error("ConfLoad asserted while the chain is shifting");

endmodule

/* HitStamper.sv */
`timescale 1ns/1ps

module HitStamper import MonopixPkg::*; (
    input  logic                  ClkBx,
    input  logic                  reset_ff,
    input  hitVecT                Hit,
    input  logic                  Pulse,
    input  logic                  ResetBcid,
    input  confT                  Conf,
    output eventT [NumFlavors-1:0] Events,
    output logic [NumFlavors-1:0] EventValid,
    output logic [NumFlavors-1:0] HitOr
);

    hitVecT               effHit;
    hitVecT               prevHit;   // Last sample for edge detection
    hitVecT               rising;
    logic                 resetBcidQ;
    logic [BcidWidth-1:0] bcidBin;
    logic [BcidWidth-1:0] bcidGray;

    // Injected pulse is shared by all flavors, mask is per column
    always_comb begin
        for (int f = 0; f < NumFlavors; f++) begin
            effHit[f] = (Hit[f] | ({NumCols{Pulse}} & Conf.ColPulseSel)) & Conf.MaskCol[f];
        end
    end

    assign rising = effHit & ~prevHit;

    // Timestamp counter
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            resetBcidQ <= 1'b0;
            bcidBin    <= '0;
        end else begin
            resetBcidQ <= ResetBcid;
            if (resetBcidQ) begin
                bcidBin <= '0;
            end else begin
                bcidBin <= bcidBin + 1'b1;
            end
        end
    end

    assign bcidGray = bcidBin ^ (bcidBin >> 1);

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            prevHit    <= '0;
            EventValid <= '0;
            HitOr      <= '0;
        end else begin
            prevHit <= effHit;
            for (int f = 0; f < NumFlavors; f++) begin
                EventValid[f] <= (|rising[f]) & Conf.EnFlavor[f];
                HitOr[f]      <= (|effHit[f]) & Conf.EnHitOr[f];
            end
        end
    end

    // Event payload, qualified by EventValid
    always_ff @(posedge ClkBx) begin
        for (int f = 0; f < NumFlavors; f++) begin
            Events[f] <= '{Cols: rising[f], Bcid: bcidGray};
        end
    end

endmodule

/* HitFifo.sv */
`timescale 1ns/1ps

module HitFifo import MonopixPkg::*; #(
    parameter int Depth = FifoDepth  // Power of two
) (
    input  logic  ClkBx,
    input  logic  reset_ff,
    input  logic  Push,
    input  eventT PushData,
    input  logic  Pop,
    output eventT Head,
    output logic  Empty,
    output logic  Full
);

    localparam int AddrWidth = $clog2(Depth);

    eventT                mem [Depth];
    logic [AddrWidth-1:0] rdPtr;
    logic [AddrWidth-1:0] wrPtr;
    logic [AddrWidth:0]   count;
    logic                 doPush;
    logic                 doPop;

    assign Empty  = (count == '0);
    assign Full   = (count == (AddrWidth+1)'(Depth));
    assign doPush = Push & ~Full;   // Overflow events are lost
    assign doPop  = Pop & ~Empty;
    assign Head   = mem[rdPtr];

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= wrPtr + 1'b1;  // Wraps at Depth
            if (doPop)  rdPtr <= rdPtr + 1'b1;
            count <= count + (AddrWidth+1)'(doPush) - (AddrWidth+1)'(doPop);
        end
    end

    always_ff @(posedge ClkBx) begin
        if (doPush) begin
            mem[wrPtr] <= PushData;
        end
    end

    // Readout must only pop a flavor it saw as non-empty
    assert property (@(posedge ClkBx) disable iff (reset_ff) Pop |-> !Empty)
        else $error("Pop on an empty event buffer");

endmodule

/* ReadoutCtrl.sv */
`timescale 1ns/1ps

module ReadoutCtrl import MonopixPkg::*; (
    input  logic                   ClkBx,
    input  logic                   reset_ff,
    input  logic [NumFlavors-1:0]  Empty,
    input  eventT [NumFlavors-1:0] Head,
    input  logic                   OutAck,
    output logic [NumFlavors-1:0]  Pop,
    output outWordT                OutWord,
    output logic                   OutReq
);

    typedef enum logic [1:0] {
        Idle,
        Request,   // OutReq high, waiting for ack
        Release    // Waiting for ack to drop
    } stateT;

    stateT                  state;
    logic [FlavorWidth-1:0] rrPtr;   // Flavor served last
    logic [FlavorWidth-1:0] sel;
    logic                   found;

    // Search starts one past the last served flavor
    always_comb begin
        logic [FlavorWidth-1:0] idx;
        found = 1'b0;
        sel   = rrPtr;
        for (int i = 1; i <= NumFlavors; i++) begin
            idx = rrPtr + FlavorWidth'(i);
            if (!found && !Empty[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    always_comb begin
        Pop = '0;
        if (state == Idle && found) Pop[sel] = 1'b1;
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            state  <= Idle;
            rrPtr  <= FlavorWidth'(NumFlavors - 1);  // First pick is flavor 0
            OutReq <= 1'b0;
        end else begin
            case (state)
                Idle: if (found) begin
                    rrPtr  <= sel;
                    OutReq <= 1'b1;
                    state  <= Request;
                end
                Request: if (OutAck) begin
                    OutReq <= 1'b0;
                    state  <= Release;
                end
                Release: if (!OutAck) state <= Idle;
                default: state <= Idle;
            endcase
        end
    end

    // Word latched together with the pop
    always_ff @(posedge ClkBx) begin
        if (state == Idle && found) begin
            OutWord <= '{Flavor: sel, Cols: Head[sel].Cols, Bcid: Head[sel].Bcid};
        end
    end

    assert property (@(posedge ClkBx) disable iff (reset_ff)
        OutReq && $past(OutReq) |-> $stable(OutWord))
        else $error("OutWord changed during a request");

endmodule

/* MonopixTop.sv */
`timescale 1ns/1ps

module MonopixTop import MonopixPkg::*; (
    input  logic                  ClkBx,
    input  logic                  reset_ff,
    input  logic                  ConfShiftEn,
    input  logic                  ConfSi,
    input  logic                  ConfLoad,
    input  hitVecT                Hit,
    input  logic                  Pulse,
    input  logic                  ResetBcid,
    input  logic                  OutAck,
    output logic                  ConfSo,
    output logic [NumFlavors-1:0] HitOr,
    output outWordT               OutWord,
    output logic                  OutReq
);

    confT                   conf;
    eventT [NumFlavors-1:0] events;
    logic [NumFlavors-1:0]  eventValid;
    eventT [NumFlavors-1:0] fifoHead;
    logic [NumFlavors-1:0]  fifoEmpty;
    logic [NumFlavors-1:0]  fifoPop;

    ConfigReg ConfigReg (
        .ClkBx       (ClkBx),
        .reset_ff    (reset_ff),
        .ConfShiftEn (ConfShiftEn),
        .ConfSi      (ConfSi),
        .ConfLoad    (ConfLoad),
        .ConfSo      (ConfSo),
        .Conf        (conf)
    );

    HitStamper HitStamper (
        .ClkBx      (ClkBx),
        .reset_ff   (reset_ff),
        .Hit        (Hit),
        .Pulse      (Pulse),
        .ResetBcid  (ResetBcid),
        .Conf       (conf),
        .Events     (events),
        .EventValid (eventValid),
        .HitOr      (HitOr)
    );

    // One buffer per flavor
    for (genvar f = 0; f < NumFlavors; f++) begin : gFifo
        HitFifo #(.Depth(FifoDepth)) HitFifo (
            .ClkBx    (ClkBx),
            .reset_ff (reset_ff),
            .Push     (eventValid[f]),
            .PushData (events[f]),
            .Pop      (fifoPop[f]),
            .Head     (fifoHead[f]),
            .Empty    (fifoEmpty[f]),
            .Full     ()
        );
    end

    ReadoutCtrl ReadoutCtrl (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .Empty    (fifoEmpty),
        .Head     (fifoHead),
        .OutAck   (OutAck),
        .Pop      (fifoPop),
        .OutWord  (OutWord),
        .OutReq   (OutReq)
    );

endmodule

/* MonopixChecker.sv */
`timescale 1ns/1ps

module MonopixChecker import MonopixPkg::*; (
    input  logic                  ClkBx,
    input  logic                  reset_ff,
    input  logic                  TestStart,
    input  logic                  ConfShiftEn,
    input  logic                  ConfSo,
    input  logic                  OutReq,
    input  outWordT               OutWord,
    input  logic [NumFlavors-1:0] HitOr
);

    outWordT               gotWords [8];
    int                    gotCount;
    int                    passCount = 0;
    int                    failCount = 0;
    logic                  reqQ;
    logic [NumFlavors-1:0] seenHitOr;
    logic [ConfWidth-1:0]  readBack;   // Old chain content, MSB first

    always @(posedge ClkBx) begin
        reqQ <= OutReq;
        if (ConfShiftEn) readBack <= {readBack[ConfWidth-2:0], ConfSo};
        if (reset_ff || TestStart) begin
            gotCount  <= 0;
            seenHitOr <= '0;
        end else begin
            seenHitOr <= seenHitOr | HitOr;
            if (OutReq && !reqQ) begin   // One word per request
                if (gotCount < 8) gotWords[gotCount] <= OutWord;
                gotCount <= gotCount + 1;
            end
        end
    end

    function automatic logic [BcidWidth-1:0] grayToBin(input logic [BcidWidth-1:0] g);
        logic [BcidWidth-1:0] b;
        b[BcidWidth-1] = g[BcidWidth-1];
        for (int i = BcidWidth - 2; i >= 0; i--) b[i] = b[i+1] ^ g[i];
        return b;
    endfunction

    // Bcid of the words is only compared as a gap between the first two
    task automatic reportTest(input string name, input outWordT [5:0] expWords,
            input int nWords, input logic [NumFlavors-1:0] expHitOr,
            input logic [ConfWidth-1:0] expConf, input int gap);
        string                msg;
        logic [BcidWidth-1:0] diff;
        msg = "";
        if (readBack !== expConf)
            msg = $sformatf("MISMATCH %s config readback expected %h actual %h",
                name, expConf, readBack);
        else if (gotCount != nWords)
            msg = $sformatf("MISMATCH %s word count expected %0d actual %0d",
                name, nWords, gotCount);
        else if (seenHitOr !== expHitOr)
            msg = $sformatf("MISMATCH %s HitOr expected %b actual %b", name, expHitOr, seenHitOr);
        for (int i = 0; i < nWords; i++) begin
            if (msg == "" && {gotWords[i].Flavor, gotWords[i].Cols} !==
                    {expWords[i].Flavor, expWords[i].Cols})
                msg = $sformatf("MISMATCH %s word %0d expected %h actual %h", name, i,
                    {expWords[i].Flavor, expWords[i].Cols},
                    {gotWords[i].Flavor, gotWords[i].Cols});
        end
        if (msg == "" && gap > 0) begin
            diff = grayToBin(gotWords[1].Bcid) - grayToBin(gotWords[0].Bcid);  // Wraps at 64
            if (int'(diff) != gap % 64)
                msg = $sformatf("MISMATCH %s Bcid gap expected %0d actual %0d",
                    name, gap % 64, diff);
        end
        if (msg == "") begin
            passCount++;
            $display("PASS %s (%0d words)", name, nWords);
        end else begin
            failCount++;
            $display("%s", msg);
        end
    endtask

    task automatic printSummary();
        $display("Tests run %0d, passed %0d, failed %0d",
            passCount + failCount, passCount, failCount);
    endtask

endmodule

/* tb_MonopixTop.sv */
`timescale 1ns/1ps

module tb_MonopixTop import MonopixPkg::*; ();

    typedef struct packed {
        confT                  conf;      // Loaded before the hits
        hitVecT                hit;
        logic                  pulse;
        logic [2:0]            reps;      // Number of hit pulses
        logic [4:0]            spacing;   // Cycles between rising edges
        logic                  shiftCols; // Move the hit up one column per pulse
        logic                  checkGap;
        logic [7:0]            ackDelay;
        logic [2:0]            nWords;
        outWordT [5:0]         words;
        logic [NumFlavors-1:0] hitOr;
    } stimT;

    logic    ClkBx;
    logic    reset_ff;
    logic    ConfShiftEn;
    logic    ConfSi;
    logic    ConfLoad;
    hitVecT  Hit;
    logic    Pulse;
    logic    ResetBcid;
    logic    OutAck = 1'b0;
    logic    ConfSo;
    logic    [NumFlavors-1:0] HitOr;
    outWordT OutWord;
    logic    OutReq;
    logic    TestStart;
    int      ackDelay;
    int      ackCnt;
    logic    timedOut;
    confT    prevConf;
    stimT    tbl [5];
    string   names [5];

    MonopixTop DUT (.*);

    MonopixChecker Checker (
        .ClkBx(ClkBx), .reset_ff(reset_ff), .TestStart(TestStart), .ConfShiftEn(ConfShiftEn),
        .ConfSo(ConfSo), .OutReq(OutReq), .OutWord(OutWord), .HitOr(HitOr)
    );

    initial begin
        ClkBx = 1'b0;
        forever #4 ClkBx = ~ClkBx;
    end

    // Ack responder, four-phase
    always @(posedge ClkBx) begin
        if (reset_ff) begin
            OutAck <= 1'b0;
            ackCnt <= 0;
        end else if (OutReq && !OutAck) begin
            if (ackCnt >= ackDelay) OutAck <= 1'b1;
            else ackCnt <= ackCnt + 1;
        end else if (!OutReq) begin
            OutAck <= 1'b0;
            ackCnt <= 0;
        end
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic buildTable();
        hitVecT     h;
        confT       c;
        logic [7:0] rndCols;
        rndCols = nextRandom(32'h5493f320) | 32'h1;  // At least one column
        h = '0;
        h[3] = rndCols;
        names[0] = "DefaultConfSingleHit";
        tbl[0] = '{conf: ConfDefault, hit: h, pulse: 1'b0, reps: 3'd1, spacing: 5'd2,
            shiftCols: 1'b0, checkGap: 1'b0, ackDelay: 8'd2, nWords: 3'd1, words: '0,
            hitOr: 4'b1000};
        tbl[0].words[0] = '{Flavor: 2'd3, Cols: rndCols, Bcid: '0};
        c = ConfDefault;
        c.ColPulseSel = 8'hA5;
        names[1] = "InjectionRoundRobin";
        tbl[1] = '{conf: c, hit: '0, pulse: 1'b1, reps: 3'd1, spacing: 5'd2, shiftCols: 1'b0,
            checkGap: 1'b0, ackDelay: 8'd1, nWords: 3'd4, words: '0, hitOr: 4'b1111};
        for (int f = 0; f < NumFlavors; f++) tbl[1].words[f] = '{f[1:0], 8'hA5, '0};
        c = ConfDefault;
        c.EnFlavor = 4'b1101;
        c.EnHitOr = 4'b1011;
        c.MaskCol[2] = 8'hF0;
        h = '0;
        h[0] = 8'h03;
        h[1] = 8'hFF;   // Flavor disabled, HitOr only
        h[2] = 8'h3C;   // Low half masked
        names[2] = "MasksAndEnables";
        tbl[2] = '{conf: c, hit: h, pulse: 1'b0, reps: 3'd1, spacing: 5'd2, shiftCols: 1'b0,
            checkGap: 1'b0, ackDelay: 8'd3, nWords: 3'd2, words: '0, hitOr: 4'b0011};
        tbl[2].words[0] = '{Flavor: 2'd0, Cols: 8'h03, Bcid: '0};
        tbl[2].words[1] = '{Flavor: 2'd2, Cols: 8'h30, Bcid: '0};
        h = '0;
        h[2] = 8'h81;
        names[3] = "TimestampGap";
        tbl[3] = '{conf: ConfDefault, hit: h, pulse: 1'b0, reps: 3'd2, spacing: 5'd13,
            shiftCols: 1'b0, checkGap: 1'b1, ackDelay: 8'd0, nWords: 3'd2, words: '0,
            hitOr: 4'b0100};
        tbl[3].words[0] = '{Flavor: 2'd2, Cols: 8'h81, Bcid: '0};
        tbl[3].words[1] = '{Flavor: 2'd2, Cols: 8'h81, Bcid: '0};
        h = '0;
        h[1] = 8'h01;
        names[4] = "BackPressure";
        tbl[4] = '{conf: ConfDefault, hit: h, pulse: 1'b0, reps: 3'd6, spacing: 5'd2,
            shiftCols: 1'b1, checkGap: 1'b0, ackDelay: 8'd30, nWords: 3'd5, words: '0,
            hitOr: 4'b0010};
        // Sixth event overflows, four buffered plus one held for readout
        for (int i = 0; i < 5; i++) tbl[4].words[i] = '{2'd1, 8'h01 << i, '0};
    endtask

    task automatic loadConfig(input confT cfg);
        logic [ConfWidth-1:0] bits;
        bits = cfg;
        @(posedge ClkBx);
        TestStart <= 1'b1;
        for (int j = ConfWidth - 1; j >= 0; j--) begin
            @(posedge ClkBx);
            TestStart   <= 1'b0;
            ConfShiftEn <= 1'b1;
            ConfSi      <= bits[j];
        end
        @(posedge ClkBx);
        ConfShiftEn <= 1'b0;
        ConfLoad    <= 1'b1;
        @(posedge ClkBx);
        ConfLoad <= 1'b0;
    endtask

    task automatic driveHits(input stimT s);
        if (s.checkGap) begin
            @(posedge ClkBx);
            ResetBcid <= 1'b1;
            @(posedge ClkBx);
            ResetBcid <= 1'b0;
            repeat (3) @(posedge ClkBx);
        end
        for (int r = 0; r < int'(s.reps); r++) begin
            @(posedge ClkBx);
            Hit   <= s.shiftCols ? hitVecT'(s.hit << r) : s.hit;
            Pulse <= s.pulse;
            @(posedge ClkBx);
            Hit   <= '0;
            Pulse <= 1'b0;
            repeat (int'(s.spacing) - 2) @(posedge ClkBx);
        end
    endtask

    task automatic waitForWords(input string name, input int n, output logic late);
        int cyc;
        cyc = 0;
        while (cyc < 500 && !(Checker.gotCount >= n && !OutReq && !OutAck)) begin
            @(posedge ClkBx);
            cyc++;
        end
        late = (cyc >= 500);
        if (late)
            $display("Timeout in %s: readout did not finish, %0d of %0d words seen",
                name, Checker.gotCount, n);
        else
            repeat (12) @(posedge ClkBx);  // Let a stray extra word show up
    endtask

    initial begin
        reset_ff    <= 1'b1;
        ConfShiftEn <= 1'b0;
        ConfSi      <= 1'b0;
        ConfLoad    <= 1'b0;
        Hit         <= '0;
        Pulse       <= 1'b0;
        ResetBcid   <= 1'b0;
        TestStart   <= 1'b0;
        ackDelay    = 0;
        timedOut    = 1'b0;
        prevConf    = ConfDefault;   // Chain content right after reset
        buildTable();
        repeat (8) @(posedge ClkBx);
        reset_ff <= 1'b0;
        for (int t = 0; t < $size(tbl) && !timedOut; t++) begin
            ackDelay = int'(tbl[t].ackDelay);
            loadConfig(tbl[t].conf);
            driveHits(tbl[t]);
            waitForWords(names[t], int'(tbl[t].nWords), timedOut);
            if (!timedOut)
                Checker.reportTest(names[t], tbl[t].words, int'(tbl[t].nWords), tbl[t].hitOr,
                    prevConf, tbl[t].checkGap ? int'(tbl[t].spacing) : 0);
            prevConf = tbl[t].conf;
        end
        Checker.printSummary();
        if (!timedOut && Checker.failCount == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* verilog.f */
MonopixPkg.sv
ConfigReg.sv
HitStamper.sv
HitFifo.sv
ReadoutCtrl.sv
MonopixTop.sv
MonopixChecker.sv
tb_MonopixTop.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_MonopixTop
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
PASS_MSG  := NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
